/* logic/bridge_pkg.sv */
package bridge_pkg;

    // bus geometry
    localparam int xlen         = 64;   // data bus and address width
    localparam int inst_width   = 32;   // one instruction lane
    localparam int axi_id_width = 4;

    // ar channel encodings
    localparam logic [7:0] axi_len_single = 8'd0;    // single beat, no bursts here
    localparam logic [2:0] axi_size_dword = 3'd3;    // 8 bytes per beat
    localparam logic [1:0] axi_burst_incr = 2'b01;

    // prot bit0 privileged, bit1 non-secure, bit2 instruction
    // all clear means unprivileged, secure, data
    localparam logic [2:0] axi_prot_data = 3'b000;

    // normal memory, non-cacheable, non-bufferable
    localparam logic [3:0] axi_cache_normal_nc = 4'b0010;

    // read response codes
    localparam logic [1:0] axi_resp_okay = 2'b00;

    // requester ids on the shared port
    localparam logic [axi_id_width-1:0] ifu_id = 4'd0;   // instruction fetch
    localparam logic [axi_id_width-1:0] lsu_id = 4'd1;   // load unit

    // payload types
    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [inst_width-1:0] inst_t;

    // read master states, gray order like the old bus bridge
    typedef enum logic [1:0] {
        rd_idle    = 2'b00,
        rd_ar_wait = 2'b01,   // ar valid up, waiting for ready
        rd_r_wait  = 2'b11,   // r ready up, waiting for the beat
        rd_done    = 2'b10    // result cached, ready to requester
    } rd_state_t;

    // address read channel, 88 bits
    typedef struct packed {
        logic [axi_id_width-1:0] id;
        logic [xlen-1:0]         addr;
        logic [7:0]              len;
        logic [2:0]              size;
        logic [1:0]              burst;
        logic [2:0]              prot;
        logic [3:0]              cache;
    } ar_chan_t;

    // read data channel, 71 bits
    typedef struct packed {
        logic [axi_id_width-1:0] id;
        logic [xlen-1:0]         data;
        logic [1:0]              resp;   // passed along, not acted on
        logic                    last;
    } r_chan_t;

endpackage

/* logic/axi_read_master.sv */
`timescale 1ns/1ps

module axi_read_master #(
    parameter type payload_t = bridge_pkg::xlen_t,
    parameter logic [bridge_pkg::axi_id_width-1:0] master_id = '0
) (
    input  logic                 clock,
    input  logic                 reset,

    // requester side, valid and address held until ready
    input  logic                 req_valid_i,
    input  bridge_pkg::xlen_t    req_addr_i,
    output logic                 req_ready_o,
    output payload_t             req_data_o,

    // ar channel toward the arbiter
    output bridge_pkg::ar_chan_t ar_o,
    output logic                 ar_valid_o,
    input  logic                 ar_ready_i,

    // r channel, valid already steered by id
    input  bridge_pkg::r_chan_t  r_i,
    input  logic                 r_valid_i,
    output logic                 r_ready_o
);

    bridge_pkg::rd_state_t state_q;
    bridge_pkg::rd_state_t state_d;

    bridge_pkg::xlen_t addr_q;   // address of the read in flight or cached
    bridge_pkg::xlen_t data_q;   // last returned beat

    logic addr_hit;    // live address matches the held one
    logic load_addr;   // capture a new address this edge
    logic r_fire;      // beat accepted

    assign addr_hit  = (req_addr_i == addr_q);
    assign r_fire    = r_valid_i && r_ready_o;

    // new read from idle, or refetch after the address moved
    assign load_addr = req_valid_i &&
                       ((state_q == bridge_pkg::rd_idle) ||
                        ((state_q == bridge_pkg::rd_done) && !addr_hit));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= bridge_pkg::rd_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            bridge_pkg::rd_idle: begin
                if (req_valid_i) state_d = bridge_pkg::rd_ar_wait;
            end
            bridge_pkg::rd_ar_wait: begin
                if (ar_ready_i) state_d = bridge_pkg::rd_r_wait;   // address taken
            end
            bridge_pkg::rd_r_wait: begin
                if (r_valid_i) state_d = bridge_pkg::rd_done;
            end
            bridge_pkg::rd_done: begin
                if (!req_valid_i) begin
                    state_d = bridge_pkg::rd_idle;       // requester let go
                end else if (!addr_hit) begin
                    state_d = bridge_pkg::rd_ar_wait;    // new address, refetch
                end
            end
            default: state_d = bridge_pkg::rd_idle;
        endcase
    end

    // address held for the whole read so ar stays stable
    always_ff @(posedge clock) begin
        if (load_addr) begin
            addr_q <= req_addr_i;
        end
    end

    // beat captured on the r handshake
    always_ff @(posedge clock) begin
        if (r_fire) begin
            data_q <= r_i.data;
        end
    end

    assign ar_valid_o = (state_q == bridge_pkg::rd_ar_wait);
    assign r_ready_o  = (state_q == bridge_pkg::rd_r_wait);

    // single beat, full width, fixed attributes
    always_comb begin
        ar_o.id    = master_id;
        ar_o.addr  = addr_q;
        ar_o.len   = bridge_pkg::axi_len_single;
        ar_o.size  = bridge_pkg::axi_size_dword;
        ar_o.burst = bridge_pkg::axi_burst_incr;
        ar_o.prot  = bridge_pkg::axi_prot_data;
        ar_o.cache = bridge_pkg::axi_cache_normal_nc;
    end

    // cached result only counts while the address has not moved
    assign req_ready_o = (state_q == bridge_pkg::rd_done) && req_valid_i && addr_hit;

    // narrow payload picks its lane with address bit 2
    if ($bits(payload_t) < bridge_pkg::xlen) begin : g_lane
        logic [bridge_pkg::inst_width-1:0] lane;

        assign lane = addr_q[2] ? data_q[bridge_pkg::inst_width +: bridge_pkg::inst_width]
                                : data_q[0 +: bridge_pkg::inst_width];
        assign req_data_o = payload_t'(lane);
    end else begin : g_word
        assign req_data_o = payload_t'(data_q);   // whole dword
    end

    // ar payload and valid must not move while stalled
    a_ar_stable: assert property (
        @(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
    ) else $error("ar channel changed under back-pressure, id %0d", master_id);

    // no ready before a beat has come back for this address
    a_ready_done: assert property (
        @(posedge clock) disable iff (!reset)
        req_ready_o |-> (state_q == bridge_pkg::rd_done) && $past(r_fire || req_ready_o)
    ) else $error("requester ready outside done, id %0d", master_id);

endmodule

/* logic/axi_read_arbiter.sv */
`timescale 1ns/1ps

module axi_read_arbiter (
    input  logic                 clock,
    input  logic                 reset,

    // fetch master ar
    input  bridge_pkg::ar_chan_t ifu_ar_i,
    input  logic                 ifu_ar_valid_i,
    output logic                 ifu_ar_ready_o,

    // load master ar
    input  bridge_pkg::ar_chan_t lsu_ar_i,
    input  logic                 lsu_ar_valid_i,
    output logic                 lsu_ar_ready_o,

    // r handshake per master, payload goes to both
    output logic                 ifu_r_valid_o,
    input  logic                 ifu_r_ready_i,
    output logic                 lsu_r_valid_o,
    input  logic                 lsu_r_ready_i,
    input  bridge_pkg::r_chan_t  r_i,

    // external port
    output bridge_pkg::ar_chan_t ar_o,
    output logic                 ar_valid_o,
    input  logic                 ar_ready_i,
    input  logic                 r_valid_i,
    output logic                 r_ready_o
);

    logic [1:0] req;       // bit 0 fetch, bit 1 load
    logic [1:0] pick;      // fresh round-robin choice
    logic [1:0] grant;     // grant in effect this cycle
    logic [1:0] grant_q;   // locked grant, zero when free
    logic       ptr_q;     // 0 favors fetch, 1 favors load
    logic       ar_fire;
    logic       r_to_ifu;
    logic       r_to_lsu;

    assign req = {lsu_ar_valid_i, ifu_ar_valid_i};

    always_comb begin
        pick = 2'b00;
        if (!ptr_q) begin
            if (req[0]) begin
                pick = 2'b01;
            end else if (req[1]) begin
                pick = 2'b10;
            end
        end else begin
            if (req[1]) begin
                pick = 2'b10;
            end else if (req[0]) begin
                pick = 2'b01;
            end
        end
    end

    // a locked grant wins over a new pick
    assign grant = (grant_q != 2'b00) ? grant_q : pick;

    assign ar_o       = grant[1] ? lsu_ar_i : ifu_ar_i;
    assign ar_valid_o = (grant[0] && ifu_ar_valid_i) || (grant[1] && lsu_ar_valid_i);
    assign ar_fire    = ar_valid_o && ar_ready_i;

    assign ifu_ar_ready_o = grant[0] && ar_ready_i;
    assign lsu_ar_ready_o = grant[1] && ar_ready_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            grant_q <= 2'b00;
            ptr_q   <= 1'b0;    // fetch first after reset
        end else if (ar_fire) begin
            grant_q <= 2'b00;
            ptr_q   <= grant[0];   // other side next time
        end else if (ar_valid_o) begin
            grant_q <= grant;       // stalled, hold the winner
        end else begin
            grant_q <= 2'b00;
        end
    end

    // r routing by id
    assign r_to_ifu = (r_i.id == bridge_pkg::ifu_id);
    assign r_to_lsu = (r_i.id == bridge_pkg::lsu_id);

    assign ifu_r_valid_o = r_valid_i && r_to_ifu;
    assign lsu_r_valid_o = r_valid_i && r_to_lsu;

    // stray ids get drained rather than stall the port
    assign r_ready_o = r_to_ifu ? ifu_r_ready_i :
                       r_to_lsu ? lsu_r_ready_i : 1'b1;

    a_grant_onehot: assert property (
        @(posedge clock) disable iff (!reset)
        $onehot0(grant)
    ) else $error("both masters granted");

    // winner cannot change in the middle of a stalled address beat
    a_grant_hold: assert property (
        @(posedge clock) disable iff (!reset)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(grant)
    ) else $error("grant moved before ar handshake");

    a_r_id_known: assert property (
        @(posedge clock) disable iff (!reset)
        r_valid_i |-> r_to_ifu || r_to_lsu
    ) else $error("r beat with unknown id %0h", r_i.id);

endmodule

/* logic/fetch_load_bridge.sv */
`timescale 1ns/1ps

module fetch_load_bridge (
    input  logic                 clock,
    input  logic                 reset,

    // instruction fetch requester
    input  logic                 ifu_valid_i,
    input  bridge_pkg::xlen_t    ifu_addr_i,
    output logic                 ifu_ready_o,
    output bridge_pkg::inst_t    ifu_inst_o,

    // load requester
    input  logic                 lsu_valid_i,
    input  bridge_pkg::xlen_t    lsu_addr_i,
    output logic                 lsu_ready_o,
    output bridge_pkg::xlen_t    lsu_data_o,

    // shared axi read port
    output bridge_pkg::ar_chan_t axi_ar_o,
    output logic                 axi_ar_valid_o,
    input  logic                 axi_ar_ready_i,
    input  bridge_pkg::r_chan_t  axi_r_i,
    input  logic                 axi_r_valid_i,
    output logic                 axi_r_ready_o
);

    bridge_pkg::ar_chan_t ifu_ar;
    logic                 ifu_ar_valid;
    logic                 ifu_ar_ready;
    logic                 ifu_r_valid;
    logic                 ifu_r_ready;

    bridge_pkg::ar_chan_t lsu_ar;
    logic                 lsu_ar_valid;
    logic                 lsu_ar_ready;
    logic                 lsu_r_valid;
    logic                 lsu_r_ready;

    // fetch side, 32-bit lane out
    axi_read_master #(
        .payload_t (bridge_pkg::inst_t),
        .master_id (bridge_pkg::ifu_id)
    ) ifu_master_i (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (ifu_valid_i),
        .req_addr_i  (ifu_addr_i),
        .req_ready_o (ifu_ready_o),
        .req_data_o  (ifu_inst_o),
        .ar_o        (ifu_ar),
        .ar_valid_o  (ifu_ar_valid),
        .ar_ready_i  (ifu_ar_ready),
        .r_i         (axi_r_i),        // payload fanned out, valid routed
        .r_valid_i   (ifu_r_valid),
        .r_ready_o   (ifu_r_ready)
    );

    // load side, full dword
    axi_read_master #(
        .payload_t (bridge_pkg::xlen_t),
        .master_id (bridge_pkg::lsu_id)
    ) lsu_master_i (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (lsu_valid_i),
        .req_addr_i  (lsu_addr_i),
        .req_ready_o (lsu_ready_o),
        .req_data_o  (lsu_data_o),
        .ar_o        (lsu_ar),
        .ar_valid_o  (lsu_ar_valid),
        .ar_ready_i  (lsu_ar_ready),
        .r_i         (axi_r_i),
        .r_valid_i   (lsu_r_valid),
        .r_ready_o   (lsu_r_ready)
    );

    axi_read_arbiter arb_i (
        .clock          (clock),
        .reset          (reset),
        .ifu_ar_i       (ifu_ar),
        .ifu_ar_valid_i (ifu_ar_valid),
        .ifu_ar_ready_o (ifu_ar_ready),
        .lsu_ar_i       (lsu_ar),
        .lsu_ar_valid_i (lsu_ar_valid),
        .lsu_ar_ready_o (lsu_ar_ready),
        .ifu_r_valid_o  (ifu_r_valid),
        .ifu_r_ready_i  (ifu_r_ready),
        .lsu_r_valid_o  (lsu_r_valid),
        .lsu_r_ready_i  (lsu_r_ready),
        .r_i            (axi_r_i),
        .ar_o           (axi_ar_o),
        .ar_valid_o     (axi_ar_valid_o),
        .ar_ready_i     (axi_ar_ready_i),
        .r_valid_i      (axi_r_valid_i),
        .r_ready_o      (axi_r_ready_o)
    );

endmodule

/* testbench/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model (
    input  logic                 clock,
    input  logic                 reset,
    input  bridge_pkg::ar_chan_t ar_i,
    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    output bridge_pkg::r_chan_t  r_o,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    output int                   error_count_o   // bad ar beats seen
);

    integer seed = 32'hcd62_eca6;
    bridge_pkg::ar_chan_t pending[$];   // accepted reads with the oldest first
    int ar_wait;                        // cycles left before ar ready
    int r_wait;                         // cycles left before next beat

    // contents follow from the address alone
    function automatic bridge_pkg::xlen_t word_at(input bridge_pkg::xlen_t addr);
        return {~addr[31:0], addr[31:0]};
    endfunction

    // single beat, dword, incr, fixed attributes and a known id
    function automatic int ar_errors(input bridge_pkg::ar_chan_t ar);
        int n;
        n = 0;
        if (ar.len != 8'd0 || ar.size != bridge_pkg::axi_size_dword ||
            ar.burst != bridge_pkg::axi_burst_incr) begin
            $display("FAILED at %0t: ar beat for %h has len %0d size %0d burst %0d",
                     $time, ar.addr, ar.len, ar.size, ar.burst);
            n++;
        end
        if (ar.prot != bridge_pkg::axi_prot_data ||
            ar.cache != bridge_pkg::axi_cache_normal_nc) begin
            $display("FAILED at %0t: ar beat for %h has prot %0h cache %0h",
                     $time, ar.addr, ar.prot, ar.cache);
            n++;
        end
        if (ar.id != bridge_pkg::ifu_id && ar.id != bridge_pkg::lsu_id) begin
            $display("FAILED at %0t: ar beat for %h has id %0h", $time, ar.addr, ar.id);
            n++;
        end
        return n;
    endfunction

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            ar_ready_o    <= 1'b0;
            r_valid_o     <= 1'b0;
            r_o           <= '0;
            ar_wait       <= 0;
            r_wait        <= 0;
            error_count_o <= 0;
            pending.delete();
        end else begin
            // r side looks at the queue before this edge's push
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                void'(pending.pop_front());
                r_wait    <= $random(seed) & 3;
            end else if (!r_valid_o && pending.size() != 0) begin
                if (r_wait == 0) begin
                    r_o.id    <= pending[0].id;
                    r_o.data  <= word_at(pending[0].addr);
                    r_o.resp  <= bridge_pkg::axi_resp_okay;
                    r_o.last  <= 1'b1;
                    r_valid_o <= 1'b1;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
            if (ar_valid_i && ar_ready_o) begin
                error_count_o <= error_count_o + ar_errors(ar_i);
                pending.push_back(ar_i);
                ar_ready_o    <= 1'b0;
                ar_wait       <= $random(seed) & 3;   // gap before the next accept
            end else if (ar_valid_i) begin
                if (ar_wait == 0) begin
                    ar_ready_o <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
        end
    end

endmodule

/* testbench/tb_fetch_load_bridge.sv */
`timescale 1ns/1ps

module tb_fetch_load_bridge;

    typedef struct packed {
        logic              ifu_valid;
        bridge_pkg::xlen_t ifu_addr;
        logic              lsu_valid;
        bridge_pkg::xlen_t lsu_addr;
        logic [3:0]        hold;        // extra cycles the result must stay put
        logic              ifu_first;   // first ar beat of the row must be fetch
        bridge_pkg::inst_t exp_ifu;
        bridge_pkg::xlen_t exp_lsu;
    } row_t;

    logic clock = 1'b0;
    logic reset;
    logic ifu_valid;
    logic lsu_valid;
    logic ifu_ready;
    logic lsu_ready;
    logic ar_valid;
    logic ar_ready;
    logic r_valid;
    logic r_ready;
    bridge_pkg::xlen_t    ifu_addr;
    bridge_pkg::xlen_t    lsu_addr;
    bridge_pkg::inst_t    ifu_inst;
    bridge_pkg::xlen_t    lsu_data;
    bridge_pkg::ar_chan_t ar;
    bridge_pkg::r_chan_t  r;
    int                   mem_errors;

    row_t   rows[$];
    logic [bridge_pkg::axi_id_width-1:0] ar_ids[$];   // ids in handshake order
    integer seed = 32'hcd62_eca6;
    int     pass_count = 0;
    int     fail_count = 0;
    int     beat_errors = 0;   // ar beats whose address is not their requester's
    logic   rows_built = 1'b0;

    always #50 clock = ~clock;   // 100 ns period

    fetch_load_bridge dut_i (
        .clock (clock), .reset (reset),
        .ifu_valid_i (ifu_valid), .ifu_addr_i (ifu_addr),
        .ifu_ready_o (ifu_ready), .ifu_inst_o (ifu_inst),
        .lsu_valid_i (lsu_valid), .lsu_addr_i (lsu_addr),
        .lsu_ready_o (lsu_ready), .lsu_data_o (lsu_data),
        .axi_ar_o (ar), .axi_ar_valid_o (ar_valid), .axi_ar_ready_i (ar_ready),
        .axi_r_i (r), .axi_r_valid_i (r_valid), .axi_r_ready_o (r_ready)
    );

    axi_mem_model mem_model_i (
        .clock (clock), .reset (reset),
        .ar_i (ar), .ar_valid_i (ar_valid), .ar_ready_o (ar_ready),
        .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready),
        .error_count_o (mem_errors)
    );

    // each id must carry the address its own requester holds
    always @(posedge clock) begin
        if (ar_valid && ar_ready) begin
            ar_ids.push_back(ar.id);
            if (ar.id == bridge_pkg::lsu_id && ar.addr !== lsu_addr ||
                ar.id == bridge_pkg::ifu_id && ar.addr !== ifu_addr) begin
                $display("FAILED at %0t: ar beat id %0h has address %h",
                         $time, ar.id, ar.addr);
                beat_errors++;
            end
        end
    end

    // memory rule with the inverted low half on top
    function automatic bridge_pkg::xlen_t mem_word(input bridge_pkg::xlen_t a);
        return {~a[31:0], a[31:0]};
    endfunction

    function automatic row_t make_row(input logic fv, input bridge_pkg::xlen_t fa,
                                      input logic lv, input bridge_pkg::xlen_t la,
                                      input logic [3:0] hold, input logic ifu_first);
        row_t              t;
        bridge_pkg::xlen_t w;
        w           = mem_word(fa);
        t.ifu_valid = fv;
        t.ifu_addr  = fa;
        t.lsu_valid = lv;
        t.lsu_addr  = la;
        t.hold      = hold;
        t.ifu_first = ifu_first;
        t.exp_ifu   = fa[2] ? w[63:32] : w[31:0];   // lane from bit 2
        t.exp_lsu   = mem_word(la);
        return t;
    endfunction

    task automatic report_result(input int n, input int errs);
        if (errs == 0) begin
            pass_count++;
            $display("test %0d passed", n);
        end else begin
            fail_count++;
            $display("test %0d failed with %0d errors", n, errs);
        end
    endtask

    task automatic run_row(input int n, input row_t t);
        int                errs;
        int                mark;
        logic              ifu_moved;
        logic              lsu_moved;
        bridge_pkg::inst_t ifu_seen;
        bridge_pkg::xlen_t lsu_seen;
        errs = 0;
        @(negedge clock);
        ifu_moved = ifu_valid && t.ifu_valid && (ifu_addr != t.ifu_addr);
        lsu_moved = lsu_valid && t.lsu_valid && (lsu_addr != t.lsu_addr);
        mark      = ar_ids.size();
        ifu_valid = t.ifu_valid;
        ifu_addr  = t.ifu_addr;
        lsu_valid = t.lsu_valid;
        lsu_addr  = t.lsu_addr;
        #1;   // ready must drop in the same cycle
        if ((ifu_moved || !t.ifu_valid) && ifu_ready ||
            (lsu_moved || !t.lsu_valid) && lsu_ready) begin
            $display("FAILED at %0t: row %0d ready still high after a change", $time, n);
            errs++;
        end
        while ((t.ifu_valid && !ifu_ready) || (t.lsu_valid && !lsu_ready)) @(negedge clock);
        if (t.ifu_valid && ifu_inst !== t.exp_ifu) begin
            $display("FAILED at %0t: row %0d fetch got %h expected %h", $time, n, ifu_inst,
                     t.exp_ifu);
            errs++;
        end
        if (t.lsu_valid && lsu_data !== t.exp_lsu) begin
            $display("FAILED at %0t: row %0d load got %h expected %h", $time, n, lsu_data,
                     t.exp_lsu);
            errs++;
        end
        if (t.ifu_first && (ar_ids.size() <= mark || ar_ids[mark] != bridge_pkg::ifu_id)) begin
            $display("FAILED at %0t: row %0d first address beat was not fetch", $time, n);
            errs++;
        end
        ifu_seen = ifu_inst;
        lsu_seen = lsu_data;
        repeat (t.hold) begin
            @(negedge clock);
            if ((t.ifu_valid && (!ifu_ready || ifu_inst !== ifu_seen)) ||
                (t.lsu_valid && (!lsu_ready || lsu_data !== lsu_seen))) begin
                $display("FAILED at %0t: row %0d result moved while held", $time, n);
                errs++;
            end
        end
        report_result(n, errs);
    endtask

    // two serialized reads with 0..3 cycle gaps plus hold fit in 48 cycles
    initial begin
        wait (rows_built);
        #((16 + rows.size() * 48 + 20) * 100);
        $display("timeout: a requester never saw ready");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int                errs;
        logic [31:0]       v;
        bridge_pkg::xlen_t fa;
        bridge_pkg::xlen_t la;
        reset     = 1'b0;
        ifu_valid = 1'b0;
        ifu_addr  = '0;
        lsu_valid = 1'b0;
        lsu_addr  = '0;
        rows.push_back(make_row(1'b1, 64'h1000, 1'b1, 64'h2008, 4'd2, 1'b1));   // same cycle
        rows.push_back(make_row(1'b0, 64'h0, 1'b0, 64'h0, 4'd0, 1'b0));
        rows.push_back(make_row(1'b1, 64'h1000, 1'b0, 64'h0, 4'd0, 1'b0));      // low lane
        rows.push_back(make_row(1'b1, 64'h1004, 1'b0, 64'h0, 4'd3, 1'b0));      // to high lane
        rows.push_back(make_row(1'b1, 64'h1004, 1'b0, 64'h0, 4'd4, 1'b0));      // held
        rows.push_back(make_row(1'b0, 64'h0, 1'b0, 64'h0, 4'd0, 1'b0));
        rows.push_back(make_row(1'b0, 64'h0, 1'b1, 64'h8000_0010, 4'd2, 1'b0));
        rows.push_back(make_row(1'b0, 64'h0, 1'b1, 64'h8000_0018, 4'd1, 1'b0));
        rows.push_back(make_row(1'b0, 64'h0, 1'b1, 64'h8000_0018, 4'd5, 1'b0));
        rows.push_back(make_row(1'b1, 64'h2004, 1'b1, 64'hdead_beef_0000_0040, 4'd1, 1'b0));
        rows.push_back(make_row(1'b1, 64'h2008, 1'b1, 64'hdead_beef_0000_0048, 4'd1, 1'b0));
        rows.push_back(make_row(1'b0, 64'h0, 1'b0, 64'h0, 4'd0, 1'b0));
        for (int i = 0; i < 24; i++) begin
            v  = $random(seed);
            fa = {$random(seed), $random(seed)} & ~64'h3;
            la = {$random(seed), $random(seed)} & ~64'h7;
            rows.push_back(make_row(v[0] || !v[1], fa, v[1], la, {2'b00, v[3:2]}, 1'b0));
        end
        rows_built = 1'b1;
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        errs = 0;
        if (ifu_ready !== 1'b0 || lsu_ready !== 1'b0 || ar_valid !== 1'b0 ||
            r_ready !== 1'b0) begin
            $display("FAILED at %0t: handshake outputs not low after reset", $time);
            errs++;
        end
        report_result(0, errs);
        foreach (rows[k]) run_row(k + 1, rows[k]);
        if (mem_errors != 0 || beat_errors != 0) begin
            $display("%0d bad address beats seen", mem_errors + beat_errors);
            fail_count++;
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim.f */
logic/bridge_pkg.sv
logic/axi_read_master.sv
logic/axi_read_arbiter.sv
logic/fetch_load_bridge.sv
testbench/axi_mem_model.sv
testbench/tb_fetch_load_bridge.sv

/* Bender.yml */
package:
  name: fetch_load_bridge

sources:
  # package first, then masters and arbiter, then the top level
  - logic/bridge_pkg.sv
  - logic/axi_read_master.sv
  - logic/axi_read_arbiter.sv
  - logic/fetch_load_bridge.sv

  - target: test
    files:
      - testbench/axi_mem_model.sv
      - testbench/tb_fetch_load_bridge.sv
